//--- common/core_pkg.sv
package core_pkg;

    parameter int unsigned ADDR_WIDTH = 32;
    parameter int unsigned DATA_WIDTH = 32;
    parameter int unsigned BYTE_LANES = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH - 1 : 0] addr_t;       // pc and byte addresses.
    typedef logic [DATA_WIDTH - 1 : 0] data_t;       // operands and results.
    typedef logic [BYTE_LANES - 1 : 0] byte_en_t;    // one write enable per byte lane.

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        INST_ALU   = 2'd0,
        INST_LOAD  = 2'd1,
        INST_STORE = 2'd2,
        INST_X     = 2'd3                            // idle, reset value.
    } inst_type_e;

    // access size of a load or store, the U forms zero-extend
    typedef enum logic [2:0] {
        RAM_B  = 3'd0,
        RAM_H  = 3'd1,
        RAM_W  = 3'd2,
        RAM_BU = 3'd3,
        RAM_HU = 3'd4,
        RAM_X  = 3'd7                                // no access, reset value.
    } ram_byt_e;

    parameter addr_t ADDR_INIT = '0;
    parameter data_t DATA_ZERO = '0;

endpackage

//--- design/exu_alu.sv
module exu_alu (
    input  core_pkg::alu_op_e    i_alu_op,
    input  core_pkg::inst_type_e i_inst_type,
    input  core_pkg::data_t      i_rs1_data,
    input  core_pkg::data_t      i_rs2_data,
    input  core_pkg::data_t      i_imm,
    input  logic                 i_use_imm,
    output core_pkg::data_t      o_res,
    output logic                 o_ram_wr_en
);

    import core_pkg::*;

    data_t      op_b;
    logic [4:0] shamt;
    data_t      alu_res;
    data_t      sum;
    data_t      diff;
    logic       lt_signed;
    logic       lt_unsigned;

    assign op_b  = i_use_imm ? i_imm : i_rs2_data;
    assign shamt = op_b[4:0];                        // rv32i uses the low five bits.

    assign sum  = i_rs1_data + op_b;
    assign diff = i_rs1_data - op_b;

    assign lt_signed   = $signed(i_rs1_data) < $signed(op_b);
    assign lt_unsigned = i_rs1_data < op_b;

    always_comb begin
        case (i_alu_op)
            ALU_ADD: begin
                alu_res = sum;
            end
            ALU_SUB: begin
                alu_res = diff;
            end
            ALU_AND: begin
                alu_res = i_rs1_data & op_b;
            end
            ALU_OR: begin
                alu_res = i_rs1_data | op_b;
            end
            ALU_XOR: begin
                alu_res = i_rs1_data ^ op_b;
            end
            ALU_SLT: begin
                alu_res = lt_signed ? data_t'(1) : DATA_ZERO;
            end
            ALU_SLTU: begin
                alu_res = lt_unsigned ? data_t'(1) : DATA_ZERO;
            end
            ALU_SLL: begin
                alu_res = i_rs1_data << shamt;
            end
            ALU_SRL: begin
                alu_res = i_rs1_data >> shamt;
            end
            ALU_SRA: begin
                alu_res = data_t'($signed(i_rs1_data) >>> shamt);
            end
            default: begin
                alu_res = DATA_ZERO;
            end
        endcase
    end

    // memory instructions always form rs1 + imm, whatever the op field holds
    always_comb begin
        case (i_inst_type)
            INST_ALU: begin
                o_res = alu_res;
            end
            INST_LOAD, INST_STORE: begin
                o_res = i_rs1_data + i_imm;          // effective address.
            end
            default: begin
                o_res = DATA_ZERO;
            end
        endcase
    end

    assign o_ram_wr_en = (i_inst_type == INST_STORE);

endmodule

//--- design/exu2lsu.sv
module exu2lsu (
    input  logic                 i_sys_clk,
    input  logic                 i_sys_rst_n,

    input  logic                 i_exu_valid,
    output logic                 o_e2l_valid,

    input  core_pkg::addr_t      i_exu_pc,
    output core_pkg::addr_t      o_e2l_pc,

    input  core_pkg::inst_type_e i_exu_ctr_inst_type,
    input  core_pkg::ram_byt_e   i_exu_ctr_ram_byt,
    input  logic                 i_exu_ctr_ram_wr_en,
    output core_pkg::inst_type_e o_e2l_ctr_inst_type,
    output core_pkg::ram_byt_e   o_e2l_ctr_ram_byt,
    output logic                 o_e2l_ctr_ram_wr_en,

    input  core_pkg::data_t      i_exu_res,
    input  core_pkg::data_t      i_exu_rs2_data,
    output core_pkg::data_t      o_e2l_res,
    output core_pkg::data_t      o_e2l_rs2_data
);

    import core_pkg::*;

    logic       r_e2l_valid;
    addr_t      r_e2l_pc;
    inst_type_e r_e2l_ctr_inst_type;
    ram_byt_e   r_e2l_ctr_ram_byt;
    logic       r_e2l_ctr_ram_wr_en;
    data_t      r_e2l_res;
    data_t      r_e2l_rs2_data;

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            r_e2l_valid <= 1'b0;
        end else begin
            r_e2l_valid <= i_exu_valid;              // one cycle strobe per instruction.
        end
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            r_e2l_pc            <= ADDR_INIT;
            r_e2l_ctr_inst_type <= INST_X;
            r_e2l_ctr_ram_byt   <= RAM_X;
            r_e2l_ctr_ram_wr_en <= 1'b0;
            r_e2l_res           <= DATA_ZERO;
            r_e2l_rs2_data      <= DATA_ZERO;
        end else if (i_exu_valid) begin
            r_e2l_pc            <= i_exu_pc;
            r_e2l_ctr_inst_type <= i_exu_ctr_inst_type;
            r_e2l_ctr_ram_byt   <= i_exu_ctr_ram_byt;
            r_e2l_ctr_ram_wr_en <= i_exu_ctr_ram_wr_en;
            r_e2l_res           <= i_exu_res;
            r_e2l_rs2_data      <= i_exu_rs2_data;
        end
    end

    assign o_e2l_valid         = r_e2l_valid;
    assign o_e2l_pc            = r_e2l_pc;
    assign o_e2l_ctr_inst_type = r_e2l_ctr_inst_type;
    assign o_e2l_ctr_ram_byt   = r_e2l_ctr_ram_byt;
    assign o_e2l_ctr_ram_wr_en = r_e2l_ctr_ram_wr_en;
    assign o_e2l_res           = r_e2l_res;
    assign o_e2l_rs2_data      = r_e2l_rs2_data;

    // the write enable comes from decode in the execute stage and must stay tied to stores
    a_wr_en_store : assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        o_e2l_ctr_ram_wr_en |-> (o_e2l_ctr_inst_type == INST_STORE)
    ) else $error("exu2lsu: ram write enable on a non-store instruction");

endmodule

//--- lsu/lsu.sv
module lsu #(
    parameter int unsigned RAM_DEPTH_WORDS = 256
) (
    input  logic                                   i_sys_clk,
    input  logic                                   i_sys_rst_n,

    input  logic                                   i_e2l_valid,
    input  core_pkg::addr_t                        i_e2l_pc,
    input  core_pkg::inst_type_e                   i_e2l_ctr_inst_type,
    input  core_pkg::ram_byt_e                     i_e2l_ctr_ram_byt,
    input  logic                                   i_e2l_ctr_ram_wr_en,
    input  core_pkg::data_t                        i_e2l_res,
    input  core_pkg::data_t                        i_e2l_rs2_data,

    input  core_pkg::data_t                        i_ram_rd_data,
    output logic [$clog2(RAM_DEPTH_WORDS) - 1 : 0] o_ram_addr,
    output logic                                   o_ram_wr_en,
    output core_pkg::byte_en_t                     o_ram_byte_en,
    output core_pkg::data_t                        o_ram_wr_data,

    output logic                                   o_wb_valid,
    output core_pkg::addr_t                        o_wb_pc,
    output core_pkg::data_t                        o_wb_data
);

    import core_pkg::*;

    localparam int unsigned RAM_AW = $clog2(RAM_DEPTH_WORDS);

    logic [1:0] addr_lo;

    logic       r_l2w_valid;
    addr_t      r_l2w_pc;
    inst_type_e r_l2w_inst_type;
    ram_byt_e   r_l2w_ram_byt;
    logic [1:0] r_l2w_addr_lo;
    data_t      r_l2w_res;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    data_t       ld_data;

    assign addr_lo = i_e2l_res[1:0];

    assign o_ram_addr  = i_e2l_res[RAM_AW + 1 : 2];  // word address.
    assign o_ram_wr_en = i_e2l_valid && i_e2l_ctr_ram_wr_en;

    // place the store data on the lanes picked by the low address bits
    always_comb begin
        case (i_e2l_ctr_ram_byt)
            RAM_B, RAM_BU: begin
                o_ram_byte_en = byte_en_t'(1) << addr_lo;
                o_ram_wr_data = data_t'(i_e2l_rs2_data[7:0]) << {addr_lo, 3'b000};
            end
            RAM_H, RAM_HU: begin
                o_ram_byte_en = addr_lo[1] ? 4'b1100 : 4'b0011;
                o_ram_wr_data = data_t'(i_e2l_rs2_data[15:0]) << {addr_lo[1], 4'b0000};
            end
            RAM_W: begin
                o_ram_byte_en = '1;
                o_ram_wr_data = i_e2l_rs2_data;
            end
            default: begin
                o_ram_byte_en = '0;
                o_ram_wr_data = i_e2l_rs2_data;
            end
        endcase
    end

    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            r_l2w_valid <= 1'b0;
        end else begin
            r_l2w_valid <= i_e2l_valid;
        end
    end

    // lines up with the ram read data, which also lands one cycle later
    always_ff @(posedge i_sys_clk) begin
        if (!i_sys_rst_n) begin
            r_l2w_pc        <= ADDR_INIT;
            r_l2w_inst_type <= INST_X;
            r_l2w_ram_byt   <= RAM_X;
            r_l2w_addr_lo   <= 2'b00;
            r_l2w_res       <= DATA_ZERO;
        end else if (i_e2l_valid) begin
            r_l2w_pc        <= i_e2l_pc;
            r_l2w_inst_type <= i_e2l_ctr_inst_type;
            r_l2w_ram_byt   <= i_e2l_ctr_ram_byt;
            r_l2w_addr_lo   <= addr_lo;
            r_l2w_res       <= i_e2l_res;
        end
    end

    assign ld_byte = i_ram_rd_data[{r_l2w_addr_lo, 3'b000} +: 8];
    assign ld_half = r_l2w_addr_lo[1] ? i_ram_rd_data[31:16] : i_ram_rd_data[15:0];

    always_comb begin
        case (r_l2w_ram_byt)
            RAM_B: begin
                ld_data = {{(DATA_WIDTH - 8){ld_byte[7]}}, ld_byte};
            end
            RAM_BU: begin
                ld_data = {{(DATA_WIDTH - 8){1'b0}}, ld_byte};
            end
            RAM_H: begin
                ld_data = {{(DATA_WIDTH - 16){ld_half[15]}}, ld_half};
            end
            RAM_HU: begin
                ld_data = {{(DATA_WIDTH - 16){1'b0}}, ld_half};
            end
            default: begin
                ld_data = i_ram_rd_data;
            end
        endcase
    end

    assign o_wb_valid = r_l2w_valid;
    assign o_wb_pc    = r_l2w_pc;
    assign o_wb_data  = (r_l2w_inst_type == INST_LOAD) ? ld_data : r_l2w_res;

    a_mem_aligned : assert property (
        @(posedge i_sys_clk) disable iff (!i_sys_rst_n)
        (i_e2l_valid && (i_e2l_ctr_inst_type inside {INST_LOAD, INST_STORE}))
        |-> (!(i_e2l_ctr_ram_byt inside {RAM_H, RAM_HU}) || !addr_lo[0])
            && ((i_e2l_ctr_ram_byt != RAM_W) || (addr_lo == 2'b00))
    ) else $error("lsu: misaligned memory access");

endmodule

//--- lsu/data_ram.sv
module data_ram #(
    parameter int unsigned RAM_DEPTH_WORDS = 256
) (
    input  logic                                   i_sys_clk,
    input  logic [$clog2(RAM_DEPTH_WORDS) - 1 : 0] i_ram_addr,
    input  logic                                   i_ram_wr_en,
    input  core_pkg::byte_en_t                     i_ram_byte_en,
    input  core_pkg::data_t                        i_ram_wr_data,
    output core_pkg::data_t                        o_ram_rd_data
);

    import core_pkg::*;

    data_t mem [RAM_DEPTH_WORDS];
    data_t r_rd_data;

    always_ff @(posedge i_sys_clk) begin
        if (i_ram_wr_en) begin
            for (int i = 0; i < BYTE_LANES; i++) begin
                if (i_ram_byte_en[i]) begin
                    mem[i_ram_addr][i * 8 +: 8] <= i_ram_wr_data[i * 8 +: 8];
                end
            end
        end
    end

    // read before write, a same-address write shows up on the next read.
    always_ff @(posedge i_sys_clk) begin
        r_rd_data <= mem[i_ram_addr];
    end

    assign o_ram_rd_data = r_rd_data;

endmodule

//--- design/ex_mem_top.sv
module ex_mem_top #(
    parameter int unsigned RAM_DEPTH_WORDS = 256
) (
    input  logic                 i_sys_clk,
    input  logic                 i_sys_rst_n,

    input  logic                 i_ex_valid,
    input  core_pkg::addr_t      i_ex_pc,
    input  core_pkg::alu_op_e    i_ex_alu_op,
    input  core_pkg::inst_type_e i_ex_inst_type,
    input  core_pkg::ram_byt_e   i_ex_ram_byt,
    input  core_pkg::data_t      i_ex_rs1_data,
    input  core_pkg::data_t      i_ex_rs2_data,
    input  core_pkg::data_t      i_ex_imm,
    input  logic                 i_ex_use_imm,

    output logic                 o_wb_valid,
    output core_pkg::addr_t      o_wb_pc,
    output core_pkg::data_t      o_wb_data
);

    import core_pkg::*;

    localparam int unsigned RAM_AW = $clog2(RAM_DEPTH_WORDS);

    data_t      exu_res;
    logic       exu_ram_wr_en;

    logic       e2l_valid;
    addr_t      e2l_pc;
    inst_type_e e2l_inst_type;
    ram_byt_e   e2l_ram_byt;
    logic       e2l_ram_wr_en;
    data_t      e2l_res;
    data_t      e2l_rs2_data;

    logic [RAM_AW - 1 : 0] ram_addr;
    logic                  ram_wr_en;
    byte_en_t              ram_byte_en;
    data_t                 ram_wr_data;
    data_t                 ram_rd_data;

    exu_alu u_exu_alu (
        .i_alu_op    (i_ex_alu_op),
        .i_inst_type (i_ex_inst_type),
        .i_rs1_data  (i_ex_rs1_data),
        .i_rs2_data  (i_ex_rs2_data),
        .i_imm       (i_ex_imm),
        .i_use_imm   (i_ex_use_imm),
        .o_res       (exu_res),
        .o_ram_wr_en (exu_ram_wr_en)
    );

    exu2lsu u_exu2lsu (
        .i_sys_clk           (i_sys_clk),
        .i_sys_rst_n         (i_sys_rst_n),
        .i_exu_valid         (i_ex_valid),
        .o_e2l_valid         (e2l_valid),
        .i_exu_pc            (i_ex_pc),
        .o_e2l_pc            (e2l_pc),
        .i_exu_ctr_inst_type (i_ex_inst_type),
        .i_exu_ctr_ram_byt   (i_ex_ram_byt),
        .i_exu_ctr_ram_wr_en (exu_ram_wr_en),
        .o_e2l_ctr_inst_type (e2l_inst_type),
        .o_e2l_ctr_ram_byt   (e2l_ram_byt),
        .o_e2l_ctr_ram_wr_en (e2l_ram_wr_en),
        .i_exu_res           (exu_res),
        .i_exu_rs2_data      (i_ex_rs2_data),
        .o_e2l_res           (e2l_res),
        .o_e2l_rs2_data      (e2l_rs2_data)
    );

    lsu #(
        .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
    ) u_lsu (
        .i_sys_clk           (i_sys_clk),
        .i_sys_rst_n         (i_sys_rst_n),
        .i_e2l_valid         (e2l_valid),
        .i_e2l_pc            (e2l_pc),
        .i_e2l_ctr_inst_type (e2l_inst_type),
        .i_e2l_ctr_ram_byt   (e2l_ram_byt),
        .i_e2l_ctr_ram_wr_en (e2l_ram_wr_en),
        .i_e2l_res           (e2l_res),
        .i_e2l_rs2_data      (e2l_rs2_data),
        .i_ram_rd_data       (ram_rd_data),
        .o_ram_addr          (ram_addr),
        .o_ram_wr_en         (ram_wr_en),
        .o_ram_byte_en       (ram_byte_en),
        .o_ram_wr_data       (ram_wr_data),
        .o_wb_valid          (o_wb_valid),
        .o_wb_pc             (o_wb_pc),
        .o_wb_data           (o_wb_data)
    );

    data_ram #(
        .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
    ) u_data_ram (
        .i_sys_clk     (i_sys_clk),
        .i_ram_addr    (ram_addr),
        .i_ram_wr_en   (ram_wr_en),
        .i_ram_byte_en (ram_byte_en),
        .i_ram_wr_data (ram_wr_data),
        .o_ram_rd_data (ram_rd_data)
    );

endmodule

//--- testbench/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int unsigned CLK_PERIOD_NS = 40,
    parameter int unsigned RST_CYCLES    = 8
) (
    output logic o_sys_clk,
    output logic o_sys_rst_n
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_sys_clk = 1'b0;
        forever #(CLK_PERIOD_NS / 2.0) o_sys_clk = ~o_sys_clk;
    end

    initial begin
        o_sys_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_sys_clk);
        o_sys_rst_n <= 1'b1;                         // released on a rising edge.
    end

endmodule

//--- testbench/tb_ex_mem_top.sv
module tb_ex_mem_top;

    timeunit 1ns;
    timeprecision 1ps;

    import core_pkg::*;

    localparam int unsigned RAM_DEPTH_WORDS = 256;
    localparam int unsigned MEM_BYTES       = RAM_DEPTH_WORDS * 4;
    localparam int          WB_LATENCY      = 2;     // cycles from issue to write-back.

    typedef struct packed {
        logic       valid;
        alu_op_e    alu_op;
        inst_type_e inst_type;
        ram_byt_e   ram_byt;
        addr_t      pc;
        data_t      rs1;
        data_t      rs2;
        data_t      imm;
        logic       use_imm;
        data_t      exp_data;
    } entry_t;

    logic       sys_clk;
    logic       sys_rst_n;
    logic       ex_valid;
    addr_t      ex_pc;
    alu_op_e    ex_alu_op;
    inst_type_e ex_inst_type;
    ram_byt_e   ex_ram_byt;
    data_t      ex_rs1_data;
    data_t      ex_rs2_data;
    data_t      ex_imm;
    logic       ex_use_imm;
    logic       wb_valid;
    addr_t      wb_pc;
    data_t      wb_data;

    logic [7:0] shadow_mem [MEM_BYTES];              // byte model of the data ram.
    entry_t     stim_q [$];
    int         exp_idx_q [$];                       // issued entries awaiting write-back.
    int         issue_cyc_q [$];                     // falling edge count at issue.
    int         pass_cnt = 0;
    int         fail_cnt = 0;
    int         err_cnt  = 0;
    int         edge_cnt = 0;
    int         cycle_cnt;

    tb_clk_gen u_tb_clk_gen (
        .o_sys_clk   (sys_clk),
        .o_sys_rst_n (sys_rst_n)
    );

    ex_mem_top #(
        .RAM_DEPTH_WORDS (RAM_DEPTH_WORDS)
    ) u_ex_mem_top (
        .i_sys_clk      (sys_clk),
        .i_sys_rst_n    (sys_rst_n),
        .i_ex_valid     (ex_valid),
        .i_ex_pc        (ex_pc),
        .i_ex_alu_op    (ex_alu_op),
        .i_ex_inst_type (ex_inst_type),
        .i_ex_ram_byt   (ex_ram_byt),
        .i_ex_rs1_data  (ex_rs1_data),
        .i_ex_rs2_data  (ex_rs2_data),
        .i_ex_imm       (ex_imm),
        .i_ex_use_imm   (ex_use_imm),
        .o_wb_valid     (wb_valid),
        .o_wb_pc        (wb_pc),
        .o_wb_data      (wb_data)
    );

    function automatic data_t alu_model(alu_op_e op, data_t a, data_t b);
        logic [4:0] sh;
        data_t      r;
        sh = b[4:0];
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_AND:  r = a & b;
            ALU_OR:   r = a | b;
            ALU_XOR:  r = a ^ b;
            ALU_SLT:  r = (a[31] != b[31]) ? data_t'(a[31]) : data_t'(a < b);
            ALU_SLTU: r = data_t'(a < b);
            ALU_SLL:  r = a << sh;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            default:  r = 'x;
        endcase
        return r;
    endfunction

    // stores update the shadow bytes and write back their address.
    function automatic data_t mem_model(entry_t e);
        addr_t ea;
        int    n;
        data_t r;
        ea = e.rs1 + e.imm;
        n  = (e.ram_byt inside {RAM_B, RAM_BU}) ? 1 : (e.ram_byt inside {RAM_H, RAM_HU}) ? 2 : 4;
        r  = '0;
        for (int i = 0; i < n; i++) begin
            if (e.inst_type == INST_STORE) begin
                shadow_mem[(ea + i) % MEM_BYTES] = e.rs2[8 * i +: 8];
            end else begin
                r[8 * i +: 8] = shadow_mem[(ea + i) % MEM_BYTES];
            end
        end
        if (e.inst_type == INST_STORE) begin
            return ea;
        end
        if (e.ram_byt == RAM_B) begin
            r = {{24{r[7]}}, r[7:0]};
        end else if (e.ram_byt == RAM_H) begin
            r = {{16{r[15]}}, r[15:0]};
        end
        return r;
    endfunction

    task automatic append_entry(input logic v, input alu_op_e op, input inst_type_e t,
                                input ram_byt_e b, input data_t rs1, input data_t rs2,
                                input data_t imm, input logic ui);
        entry_t e;
        e = '{v, op, t, b, addr_t'(32'h2000 + 4 * stim_q.size()), rs1, rs2, imm, ui, DATA_ZERO};
        if (v && t == INST_ALU) begin
            e.exp_data = alu_model(op, rs1, ui ? imm : rs2);
        end else if (v) begin
            e.exp_data = mem_model(e);
        end
        stim_q.push_back(e);
    endtask

    task automatic idle_gap();
        append_entry(1'b0, ALU_ADD, INST_X, RAM_X, '0, '0, '0, 1'b0);
    endtask

    task automatic store_op(input ram_byt_e b, input data_t base, input data_t wdata,
                            input data_t ofs);
        append_entry(1'b1, ALU_SUB, INST_STORE, b, base, wdata, ofs, 1'b1);
    endtask

    task automatic load_op(input ram_byt_e b, input data_t base, input data_t ofs);
        append_entry(1'b1, ALU_XOR, INST_LOAD, b, base, 32'hdead_beef, ofs, 1'b1);
    endtask

    task automatic build_stimulus();
        repeat (3) idle_gap();                       // nothing may come out yet.
        append_entry(1'b1, ALU_ADD, INST_ALU, RAM_X, 32'hffff_ffff, 32'h1, 32'h77, 1'b0);
        append_entry(1'b1, ALU_SUB, INST_ALU, RAM_X, 32'h3, 32'h5, 32'h0, 1'b0);
        append_entry(1'b1, ALU_AND, INST_ALU, RAM_X, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 1'b0);
        append_entry(1'b1, ALU_OR, INST_ALU, RAM_X, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 1'b0);
        append_entry(1'b1, ALU_XOR, INST_ALU, RAM_X, 32'hf0f0_1234, 32'h0ff0_ff00, 32'h0, 1'b0);
        append_entry(1'b1, ALU_SLT, INST_ALU, RAM_X, 32'hffff_fff0, 32'h1, 32'h0, 1'b0);
        append_entry(1'b1, ALU_SLTU, INST_ALU, RAM_X, 32'hffff_fff0, 32'h1, 32'h0, 1'b0);
        append_entry(1'b1, ALU_SLL, INST_ALU, RAM_X, 32'h8000_0001, 32'h24, 32'h0, 1'b0);
        append_entry(1'b1, ALU_SRL, INST_ALU, RAM_X, 32'h8000_0000, 32'h1f, 32'h0, 1'b0);
        append_entry(1'b1, ALU_SRA, INST_ALU, RAM_X, 32'h8000_0000, 32'h1f, 32'h0, 1'b0);
        append_entry(1'b1, ALU_SLT, INST_ALU, RAM_X, 32'hffff_ff00, 32'h5, 32'h0, 1'b1);
        append_entry(1'b1, ALU_SRA, INST_ALU, RAM_X, 32'hf000_0000, 32'h1, 32'h404, 1'b1);
        idle_gap();
        for (int op = 0; op < 10; op++) begin
            append_entry(1'b1, alu_op_e'(op), INST_ALU, RAM_X, $urandom, $urandom, $urandom,
                          op[0]);
        end
        store_op(RAM_W, 32'h100, 32'h1122_3344, 32'h0);
        load_op(RAM_W, 32'h100, 32'h0);              // right behind the store.
        store_op(RAM_W, 32'h100, 32'ha5a5_a5a5, 32'h4);
        store_op(RAM_W, 32'h100, 32'h0, 32'h8);
        store_op(RAM_W, 32'h100, 32'h80f1_7f01, 32'hc);
        idle_gap();
        load_op(RAM_W, 32'h100, 32'h4);
        for (int ofs = 0; ofs < 4; ofs++) begin
            store_op(RAM_B, 32'h104, 32'hffff_ff11 * (ofs + 1), ofs);
            load_op(RAM_W, 32'h104, 32'h0);
        end
        store_op(RAM_H, 32'h108, 32'h1234_beef, 32'h2);
        load_op(RAM_W, 32'h108, 32'h0);
        idle_gap();
        store_op(RAM_H, 32'h108, 32'h0000_cafe, 32'h0);
        load_op(RAM_W, 32'h108, 32'h0);
        for (int ofs = 0; ofs < 4; ofs++) begin
            load_op(RAM_B, 32'h10c, ofs);
            load_op(RAM_BU, 32'h10c, ofs);
        end
        load_op(RAM_H, 32'h10c, 32'h0);
        load_op(RAM_H, 32'h10c, 32'h2);
        load_op(RAM_HU, 32'h10c, 32'h0);
        load_op(RAM_HU, 32'h10c, 32'h2);
        load_op(RAM_W, 32'h110, 32'hffff_fffc);      // negative offset.
        repeat (2) idle_gap();
    endtask

    task automatic check_result(input int idx, input int lat);
        logic ok;
        ok = 1'b1;
        if (lat != WB_LATENCY) begin
            $display("entry %0d came back %0d cycles after issue instead of %0d", idx, lat,
                     WB_LATENCY);
            ok = 1'b0;
        end
        if (wb_pc !== stim_q[idx].pc) begin
            $display("FAIL entry %0d o_wb_pc 0x%h expected 0x%h", idx, wb_pc, stim_q[idx].pc);
            ok = 1'b0;
        end
        if (wb_data !== stim_q[idx].exp_data) begin
            $display("FAIL entry %0d o_wb_data 0x%h expected 0x%h", idx, wb_data,
                     stim_q[idx].exp_data);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
            $display("entry %0d pc 0x%h data 0x%h ok", idx, wb_pc, wb_data);
        end else begin
            fail_cnt++;
        end
    endtask

    // write-back is sampled on the falling edge once reset is released.
    always @(negedge sys_clk) begin
        if (sys_rst_n === 1'b1) begin
            if (wb_valid === 1'b1) begin
                if (exp_idx_q.size() == 0) begin
                    $display("o_wb_valid went high with no instruction in flight at %0t",
                             $time);
                    err_cnt++;
                end else begin
                    check_result(exp_idx_q.pop_front(), edge_cnt - issue_cyc_q.pop_front());
                end
            end else if (wb_valid !== 1'b0) begin
                $display("o_wb_valid is unknown at %0t", $time);
                err_cnt++;
            end
        end
        edge_cnt++;
    end

    initial begin
        cycle_cnt = 0;
        wait (sys_rst_n === 1'b1);
        while (cycle_cnt < stim_q.size() + 20) begin
            @(posedge sys_clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, %0d results never came back", cycle_cnt,
                 exp_idx_q.size());
        $display("Verification failed");
        $finish;
    end

    initial begin
        ex_valid     = 1'b0;
        ex_pc        = ADDR_INIT;
        ex_alu_op    = ALU_ADD;
        ex_inst_type = INST_X;
        ex_ram_byt   = RAM_X;
        ex_rs1_data  = DATA_ZERO;
        ex_rs2_data  = DATA_ZERO;
        ex_imm       = DATA_ZERO;
        ex_use_imm   = 1'b0;
        void'($urandom(32'he460));
        build_stimulus();
        wait (sys_rst_n === 1'b1);
        foreach (stim_q[i]) begin
            @(posedge sys_clk);
            ex_valid     <= stim_q[i].valid;
            ex_pc        <= stim_q[i].pc;
            ex_alu_op    <= stim_q[i].alu_op;
            ex_inst_type <= stim_q[i].inst_type;
            ex_ram_byt   <= stim_q[i].ram_byt;
            ex_rs1_data  <= stim_q[i].rs1;
            ex_rs2_data  <= stim_q[i].rs2;
            ex_imm       <= stim_q[i].imm;
            ex_use_imm   <= stim_q[i].use_imm;
            if (stim_q[i].valid) begin
                exp_idx_q.push_back(i);
                issue_cyc_q.push_back(edge_cnt);
            end
        end
        @(posedge sys_clk);
        ex_valid <= 1'b0;
        while (exp_idx_q.size() != 0) begin
            @(posedge sys_clk);
        end
        repeat (4) @(posedge sys_clk);               // catch any stray write-back.
        $display("tests %0d, passed %0d, failed %0d, other errors %0d", pass_cnt + fail_cnt,
                 pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0 && pass_cnt > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- compile.f
common/core_pkg.sv
design/exu_alu.sv
design/exu2lsu.sv
lsu/lsu.sv
lsu/data_ram.sv
design/ex_mem_top.sv
testbench/tb_clk_gen.sv
testbench/tb_ex_mem_top.sv

//--- Bender.yml
package:
  name: ex_mem_top

sources:
  - common/core_pkg.sv
  - design/exu_alu.sv
  - design/exu2lsu.sv
  - lsu/lsu.sv
  - lsu/data_ram.sv
  - design/ex_mem_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_ex_mem_top.sv
